/* rtl/dataflowPkg.sv */
package dataflowPkg;

  // one byte on any internal bus or in any register
  typedef logic [7:0] busByte;

  // bit positions inside the microinstruction flag vector
  typedef enum int unsigned {
    // register loads, committed in stage 3
    loadX,
    loadY,
    loadAcc,
    loadSp,
    loadAbl,
    loadAbh,
    loadDor,
    loadAluA,
    loadAluB,
    loadAluHold,
    // DB drivers
    setDbToData,
    setDbToAcc,
    setDbToDor,
    // SB drivers
    setSbToX,
    setSbToY,
    setSbToAcc,
    setSbToSp,
    setSbToAlu,
    // address bus drivers
    setAdhToData,
    setAdlToAlu,
    setAdlToSp,
    // pass-gate bridges
    bridgeSbDb,
    bridgeSbAdh
  } flagIndex;

  localparam int FlagCount = 23;

  // one bit per flagIndex entry
  typedef logic [FlagCount-1:0] flagVector;

  // ALU operation select
  typedef logic [2:0] aluOpCode;

  localparam aluOpCode AluAdd = 3'd0;
  localparam aluOpCode AluAnd = 3'd1;
  localparam aluOpCode AluOr  = 3'd2;
  localparam aluOpCode AluXor = 3'd3;
  localparam aluOpCode AluShr = 3'd4;

  // NMOS buses idle high, drivers can only pull bits low
  localparam busByte BusPrecharge = 8'hFF;

endpackage

/* rtl/microOpIf.sv */
`timescale 1ns/1ns

// latched microinstruction, latch stage to bus stage
interface microOpIf;
  import dataflowPkg::*;

  // one item per cycle, no back-pressure
  logic      valid;
  flagVector flags;
  aluOpCode  aluOp;
  // external data bus byte captured with the step
  busByte    dataIn;

  // written by microOpLatch
  modport source (
    output valid,
    output flags,
    output aluOp,
    output dataIn
  );

  // read by busNetwork
  modport sink (
    input valid,
    input flags,
    input aluOp,
    input dataIn
  );

endinterface

/* rtl/registerBank.sv */
`timescale 1ns/1ns

// register values after this cycle's commit, fed back to the bus stage
interface regViewIf;
  import dataflowPkg::*;

  busByte x;
  busByte y;
  busByte acc;
  busByte sp;
  busByte dor;
  busByte aluHold;

  modport source (
    output x,
    output y,
    output acc,
    output sp,
    output dor,
    output aluHold
  );

  modport sink (
    input x,
    input y,
    input acc,
    input sp,
    input dor,
    input aluHold
  );

endinterface

module registerBank #(
  parameter dataflowPkg::busByte DataResetValue = 8'h00
) (
  input  logic                clk,
  input  logic                rstN,
  busStateIf.sink             bus,
  regViewIf.source            view,
  output dataflowPkg::busByte addressLow,
  output dataflowPkg::busByte addressHigh,
  output dataflowPkg::busByte dataOut,
  output dataflowPkg::busByte debugDb,
  output logic                commitValid
);
  import dataflowPkg::*;

  // current register state
  busByte xReg, yReg, accReg, spReg;
  busByte ablReg, abhReg, dorReg;
  busByte aluAReg, aluBReg, aluHoldReg;
  logic   carryReg;

  // next state after the stage-3 item
  busByte xNext, yNext, accNext, spNext;
  busByte ablNext, abhNext, dorNext;
  busByte aluANext, aluBNext, aluHoldNext;
  logic   carryNext;

  // ALU sees the latches before this commit
  busByte aluResult;
  logic   aluCarry;

  aluUnit alu (
    .a        (aluAReg),
    .b        (aluBReg),
    .carryIn  (carryReg),
    .aluOp    (bus.aluOp),
    .result   (aluResult),
    .carryOut (aluCarry)
  );

  // loads only count for a valid item
  logic commit;
  assign commit = bus.valid;

  always_comb begin
    xNext       = commit && bus.flags[loadX]    ? bus.sb  : xReg;
    yNext       = commit && bus.flags[loadY]    ? bus.sb  : yReg;
    accNext     = commit && bus.flags[loadAcc]  ? bus.sb  : accReg;
    spNext      = commit && bus.flags[loadSp]   ? bus.sb  : spReg;
    ablNext     = commit && bus.flags[loadAbl]  ? bus.adl : ablReg;
    abhNext     = commit && bus.flags[loadAbh]  ? bus.adh : abhReg;
    dorNext     = commit && bus.flags[loadDor]  ? bus.db  : dorReg;
    aluANext    = commit && bus.flags[loadAluA] ? bus.sb  : aluAReg;
    aluBNext    = commit && bus.flags[loadAluB] ? bus.db  : aluBReg;
    // hold and carry update together
    aluHoldNext = aluHoldReg;
    carryNext   = carryReg;
    if (commit && bus.flags[loadAluHold]) begin
      aluHoldNext = aluResult;
      carryNext   = aluCarry;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      xReg        <= DataResetValue;
      yReg        <= DataResetValue;
      accReg      <= DataResetValue;
      spReg       <= DataResetValue;
      ablReg      <= DataResetValue;
      abhReg      <= DataResetValue;
      dorReg      <= DataResetValue;
      aluAReg     <= DataResetValue;
      aluBReg     <= DataResetValue;
      aluHoldReg  <= DataResetValue;
      carryReg    <= 1'b0;
      debugDb     <= DataResetValue;
      commitValid <= 1'b0;
    end else begin
      xReg        <= xNext;
      yReg        <= yNext;
      accReg      <= accNext;
      spReg       <= spNext;
      ablReg      <= ablNext;
      abhReg      <= abhNext;
      dorReg      <= dorNext;
      aluAReg     <= aluANext;
      aluBReg     <= aluBNext;
      aluHoldReg  <= aluHoldNext;
      carryReg    <= carryNext;
      // snapshot of DB for each committed item
      if (commit) debugDb <= bus.db;
      commitValid <= commit;
    end
  end

  // forwarding path, next-state values
  assign view.x       = xNext;
  assign view.y       = yNext;
  assign view.acc     = accNext;
  assign view.sp      = spNext;
  assign view.dor     = dorNext;
  assign view.aluHold = aluHoldNext;

  assign addressLow  = ablReg;
  assign addressHigh = abhReg;
  assign dataOut     = dorReg;

endmodule

/* rtl/busNetwork.sv */
`timescale 1ns/1ns

// resolved buses of one microinstruction, bus stage to register stage
interface busStateIf;
  import dataflowPkg::*;

  logic      valid;
  flagVector flags;
  aluOpCode  aluOp;
  busByte    db;
  busByte    sb;
  busByte    adh;
  busByte    adl;

  modport source (
    output valid,
    output flags,
    output aluOp,
    output db,
    output sb,
    output adh,
    output adl
  );

  modport sink (
    input valid,
    input flags,
    input aluOp,
    input db,
    input sb,
    input adh,
    input adl
  );

endinterface

module busNetwork (
  input  logic      clk,
  input  logic      rstN,
  microOpIf.sink    op,
  regViewIf.sink    view,
  busStateIf.source bus
);
  import dataflowPkg::*;

  // per-bus AND of its own drivers, before bridging
  busByte dbDrive;
  busByte sbDrive;
  busByte adhDrive;
  busByte adlDrive;
  // values after the bridge groups are joined
  busByte sbGroup;
  busByte dbResolved;
  busByte adhResolved;

  // drivers read the forwarded view, so the item in stage 3 is already seen
  always_comb begin
    dbDrive  = BusPrecharge;
    sbDrive  = BusPrecharge;
    adhDrive = BusPrecharge;
    adlDrive = BusPrecharge;

    // DB
    if (op.flags[setDbToData]) dbDrive = dbDrive & op.dataIn;
    if (op.flags[setDbToAcc])  dbDrive = dbDrive & view.acc;
    if (op.flags[setDbToDor])  dbDrive = dbDrive & view.dor;

    // SB
    if (op.flags[setSbToX])   sbDrive = sbDrive & view.x;
    if (op.flags[setSbToY])   sbDrive = sbDrive & view.y;
    if (op.flags[setSbToAcc]) sbDrive = sbDrive & view.acc;
    if (op.flags[setSbToSp])  sbDrive = sbDrive & view.sp;
    if (op.flags[setSbToAlu]) sbDrive = sbDrive & view.aluHold;

    // ADH
    if (op.flags[setAdhToData]) adhDrive = adhDrive & op.dataIn;

    // ADL, never bridged
    if (op.flags[setAdlToAlu]) adlDrive = adlDrive & view.aluHold;
    if (op.flags[setAdlToSp])  adlDrive = adlDrive & view.sp;
  end

  // SB sits in the middle, so both bridges meet there
  // DB and ADH end up joined when both are closed
  always_comb begin
    sbGroup = sbDrive;
    if (op.flags[bridgeSbDb])  sbGroup = sbGroup & dbDrive;
    if (op.flags[bridgeSbAdh]) sbGroup = sbGroup & adhDrive;

    dbResolved  = op.flags[bridgeSbDb]  ? sbGroup : dbDrive;
    adhResolved = op.flags[bridgeSbAdh] ? sbGroup : adhDrive;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      bus.valid <= 1'b0;
    end else begin
      bus.valid <= op.valid;
    end
  end

  // bus values and the flags travel on together into stage 3
  always_ff @(posedge clk) begin
    bus.flags <= op.flags;
    bus.aluOp <= op.aluOp;
    bus.db    <= dbResolved;
    bus.sb    <= sbGroup;
    bus.adh   <= adhResolved;
    bus.adl   <= adlDrive;
  end

endmodule

/* rtl/aluUnit.sv */
`timescale 1ns/1ns

module aluUnit (
  input  dataflowPkg::busByte   a,
  input  dataflowPkg::busByte   b,
  input  logic                  carryIn,
  input  dataflowPkg::aluOpCode aluOp,
  output dataflowPkg::busByte   result,
  output logic                  carryOut
);
  import dataflowPkg::*;

  // full 9-bit sum, top bit is the carry out
  logic [8:0] sum;

  assign sum = {1'b0, a} + {1'b0, b} + {8'd0, carryIn};

  always_comb begin
    // logic ops leave carry alone
    result   = a;
    carryOut = carryIn;
    case (aluOp)
      AluAdd: begin
        result   = sum[7:0];
        carryOut = sum[8];
      end
      AluAnd: begin
        result = a & b;
      end
      AluOr: begin
        result = a | b;
      end
      AluXor: begin
        result = a ^ b;
      end
      AluShr: begin
        // rotate through carry, old carry into bit 7
        result   = {carryIn, a[7:1]};
        carryOut = a[0];
      end
      default: begin
        // unused codes pass a through
        result   = a;
        carryOut = carryIn;
      end
    endcase
  end

endmodule

/* rtl/microOpLatch.sv */
`timescale 1ns/1ns

module microOpLatch (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 step,
  input  dataflowPkg::flagVector flags,
  input  dataflowPkg::aluOpCode  aluOp,
  input  dataflowPkg::busByte    dataIn,
  microOpIf.source             op
);
  import dataflowPkg::*;

  // stage 1 valid follows the step strobe by one edge
  always_ff @(posedge clk) begin
    if (!rstN) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= step;
    end
  end

  // payload only moves on a step
  // otherwise the previous item stays visible but is not valid
  always_ff @(posedge clk) begin
    if (step) begin
      op.flags  <= flags;
      op.aluOp  <= aluOp;
      // external bus byte sampled at the same edge as the flags
      op.dataIn <= dataIn;
    end
  end

endmodule

/* rtl/dataflowTop.sv */
`timescale 1ns/1ns

module dataflowTop #(
  parameter dataflowPkg::busByte DataResetValue = 8'h00
) (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   step,
  input  dataflowPkg::flagVector flags,
  input  dataflowPkg::aluOpCode  aluOp,
  input  dataflowPkg::busByte    dataIn,
  output dataflowPkg::busByte    addressLow,
  output dataflowPkg::busByte    addressHigh,
  output dataflowPkg::busByte    dataOut,
  output dataflowPkg::busByte    debugDb,
  output logic                   commitValid
);

  // stage links
  microOpIf  opLink ();
  busStateIf busLink ();
  // forwarding from stage 3 back into stage 2
  regViewIf  viewLink ();

  // stage 1
  microOpLatch latchStage (
    .clk    (clk),
    .rstN   (rstN),
    .step   (step),
    .flags  (flags),
    .aluOp  (aluOp),
    .dataIn (dataIn),
    .op     (opLink.source)
  );

  // stage 2
  busNetwork busStage (
    .clk  (clk),
    .rstN (rstN),
    .op   (opLink.sink),
    .view (viewLink.sink),
    .bus  (busLink.source)
  );

  // stage 3
  registerBank #(
    .DataResetValue (DataResetValue)
  ) regStage (
    .clk         (clk),
    .rstN        (rstN),
    .bus         (busLink.sink),
    .view        (viewLink.source),
    .addressLow  (addressLow),
    .addressHigh (addressHigh),
    .dataOut     (dataOut),
    .debugDb     (debugDb),
    .commitValid (commitValid)
  );

endmodule

/* tests/dataflowTb.sv */
`timescale 1ns/1ns

module dataflowTb;
  import dataflowPkg::*;

  localparam busByte ResetValue = 8'h6D;
  localparam int Latency = 3;
  localparam int DrainLimit = 40;
  localparam int RandomOps = 200;
  // x^32 + x^22 + x^2 + x + 1, right-shifting form
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic      clk;
  logic      rstN;
  logic      step;
  flagVector flags;
  aluOpCode  aluOp;
  busByte    dataIn;
  busByte    addressLow;
  busByte    addressHigh;
  busByte    dataOut;
  busByte    debugDb;
  logic      commitValid;

  // reference register set, updated in issue order
  busByte modelX, modelY, modelAcc, modelSp;
  busByte modelAbl, modelAbh, modelDor;
  busByte modelAluA, modelAluB, modelAluHold;
  logic   modelCarry;

  logic [31:0] lfsrState;
  // {addressLow, addressHigh, dataOut, debugDb} per issued step
  logic [31:0] expectQ[$];
  int          issueQ[$];

  int    cycleCount = 0;
  int    checkErrors = 0;
  int    seqErrors = 0;
  int    checkCount = 0;
  int    testsRun = 0;
  int    testsFailed = 0;
  int    testErrorBase = 0;
  string testName = "startup";

  dataflowTop #(
    .DataResetValue (ResetValue)
  ) dut_i (
    .clk         (clk),
    .rstN        (rstN),
    .step        (step),
    .flags       (flags),
    .aluOp       (aluOp),
    .dataIn      (dataIn),
    .addressLow  (addressLow),
    .addressHigh (addressHigh),
    .dataOut     (dataOut),
    .debugDb     (debugDb),
    .commitValid (commitValid)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  // one shift per random bit
  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ LfsrTaps) : (lfsrState >> 1);
    end
    return value;
  endfunction

  function automatic flagVector flagBit(input flagIndex idx);
    return flagVector'(1) << idx;
  endfunction

  function automatic int totalErrors();
    return checkErrors + seqErrors;
  endfunction

  function automatic bit byteMatches(input string what, input busByte expected,
                                     input busByte actual);
    bit ok;
    ok = 1'b1;
    assert (actual === expected) else begin
      $display("MISMATCH %s %s expected %h actual %h", testName, what, expected, actual);
      ok = 1'b0;
    end
    return ok;
  endfunction

  // sequential model of one microinstruction
  function automatic logic [31:0] modelStep(input flagVector f, input aluOpCode op,
                                            input busByte data);
    busByte     db;
    busByte     sb;
    busByte     adh;
    busByte     adl;
    busByte     aluRes;
    logic       aluC;
    logic [8:0] wide;
    db  = 8'hFF;
    sb  = 8'hFF;
    adh = 8'hFF;
    adl = 8'hFF;
    if (f[setDbToData]) db = db & data;
    if (f[setDbToAcc]) db = db & modelAcc;
    if (f[setDbToDor]) db = db & modelDor;
    if (f[setSbToX]) sb = sb & modelX;
    if (f[setSbToY]) sb = sb & modelY;
    if (f[setSbToAcc]) sb = sb & modelAcc;
    if (f[setSbToSp]) sb = sb & modelSp;
    if (f[setSbToAlu]) sb = sb & modelAluHold;
    if (f[setAdhToData]) adh = adh & data;
    if (f[setAdlToAlu]) adl = adl & modelAluHold;
    if (f[setAdlToSp]) adl = adl & modelSp;
    // wired-AND across every closed bridge, SB is the hub
    if (f[bridgeSbDb]) sb = sb & db;
    if (f[bridgeSbAdh]) sb = sb & adh;
    if (f[bridgeSbDb]) db = sb;
    if (f[bridgeSbAdh]) adh = sb;
    // ALU from latches as they stood before this item
    wide   = 9'(modelAluA) + 9'(modelAluB) + 9'(modelCarry);
    aluRes = modelAluA;
    aluC   = modelCarry;
    case (op)
      AluAdd: begin
        aluRes = wide[7:0];
        aluC   = wide[8];
      end
      AluAnd: aluRes = modelAluA & modelAluB;
      AluOr: aluRes = modelAluA | modelAluB;
      AluXor: aluRes = modelAluA ^ modelAluB;
      AluShr: begin
        aluRes = {modelCarry, modelAluA[7:1]};
        aluC   = modelAluA[0];
      end
      default: aluRes = modelAluA;
    endcase
    if (f[loadX]) modelX = sb;
    if (f[loadY]) modelY = sb;
    if (f[loadAcc]) modelAcc = sb;
    if (f[loadSp]) modelSp = sb;
    if (f[loadAbl]) modelAbl = adl;
    if (f[loadAbh]) modelAbh = adh;
    if (f[loadDor]) modelDor = db;
    if (f[loadAluA]) modelAluA = sb;
    if (f[loadAluB]) modelAluB = db;
    if (f[loadAluHold]) begin
      modelAluHold = aluRes;
      modelCarry   = aluC;
    end
    return {modelAbl, modelAbh, modelDor, db};
  endfunction

  task automatic modelReset();
    modelX       = ResetValue;
    modelY       = ResetValue;
    modelAcc     = ResetValue;
    modelSp      = ResetValue;
    modelAbl     = ResetValue;
    modelAbh     = ResetValue;
    modelDor     = ResetValue;
    modelAluA    = ResetValue;
    modelAluB    = ResetValue;
    modelAluHold = ResetValue;
    modelCarry   = 1'b0;
  endtask

  // step stays high until the next drive, so calls in a row go back to back
  task automatic sendOp(input flagVector f, input aluOpCode op, input busByte data);
    @(negedge clk);
    step   = 1'b1;
    flags  = f;
    aluOp  = op;
    dataIn = data;
    expectQ.push_back(modelStep(f, op, data));
    issueQ.push_back(cycleCount);
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(negedge clk);
      step = 1'b0;
    end
  endtask

  task automatic drainPipeline();
    int waited;
    waited = 0;
    while (expectQ.size() != 0 && waited < DrainLimit) begin
      @(posedge clk);
      waited++;
    end
    if (expectQ.size() != 0) begin
      $display("timeout: %0d steps in %s never committed", expectQ.size(), testName);
      seqErrors++;
      expectQ.delete();
      issueQ.delete();
    end
  endtask

  task automatic startTest(input string name);
    testName      = name;
    testErrorBase = totalErrors();
  endtask

  task automatic finishTest();
    idleCycles(1);
    drainPipeline();
    testsRun++;
    if (totalErrors() != testErrorBase) begin
      testsFailed++;
      $display("test %-20s failed", testName);
    end else begin
      $display("test %-20s passed", testName);
    end
  endtask

  // compares each commit against the head of the queue
  always @(negedge clk) begin : commitCheck
    logic [31:0] expected;
    int          issued;
    if (rstN) begin
      if (commitValid) begin
        assert (expectQ.size() != 0) else begin
          $display("commitValid pulsed with no step pending in %s", testName);
          checkErrors++;
        end
        if (expectQ.size() != 0) begin
          expected = expectQ.pop_front();
          issued   = issueQ.pop_front();
          checkCount++;
          assert (cycleCount - issued == Latency) else begin
            $display("commitValid came %0d cycles after its step in %s, expected %0d",
                     cycleCount - issued, testName, Latency);
            checkErrors++;
          end
          if (!byteMatches("addressLow", expected[31:24], addressLow)) checkErrors++;
          if (!byteMatches("addressHigh", expected[23:16], addressHigh)) checkErrors++;
          if (!byteMatches("dataOut", expected[15:8], dataOut)) checkErrors++;
          if (!byteMatches("debugDb", expected[7:0], debugDb)) checkErrors++;
        end
      end else if (issueQ.size() != 0) begin
        assert (cycleCount - issueQ[0] < Latency) else begin
          $display("no commitValid %0d cycles after a step in %s", Latency, testName);
          checkErrors++;
          void'(expectQ.pop_front());
          void'(issueQ.pop_front());
        end
      end
    end
  end

  task automatic aluReadback(input aluOpCode op);
    sendOp(flagBit(loadAluHold), op, 8'h00);
    // hold onto SB, across to DB and the DOR, and out on ADL
    sendOp(flagBit(setSbToAlu) | flagBit(bridgeSbDb) | flagBit(loadDor) |
           flagBit(setAdlToAlu) | flagBit(loadAbl), AluAdd, 8'h00);
  endtask

  task automatic testResetState();
    startTest("reset state");
    repeat (4) begin
      @(negedge clk);
      assert (commitValid === 1'b0) else begin
        $display("commitValid is not low after reset");
        seqErrors++;
      end
      if (!byteMatches("addressLow", ResetValue, addressLow)) seqErrors++;
      if (!byteMatches("addressHigh", ResetValue, addressHigh)) seqErrors++;
      if (!byteMatches("dataOut", ResetValue, dataOut)) seqErrors++;
      if (!byteMatches("debugDb", ResetValue, debugDb)) seqErrors++;
    end
    finishTest();
  endtask

  task automatic testDataPaths();
    startTest("data paths");
    sendOp(flagBit(setDbToData) | flagBit(loadDor), AluAdd, 8'hA5);
    idleCycles(2);
    sendOp(flagBit(setAdhToData) | flagBit(loadAbh), AluAdd, 8'h3C);
    idleCycles(2);
    // data onto DB, bridged to SB into the accumulator
    sendOp(flagBit(setDbToData) | flagBit(bridgeSbDb) | flagBit(loadAcc), AluAdd, 8'h5A);
    idleCycles(3);
    sendOp(flagBit(setDbToAcc) | flagBit(loadDor), AluAdd, 8'h00);
    finishTest();
  endtask

  task automatic testWiredAnd();
    flagVector viaDb;
    viaDb = flagBit(setDbToData) | flagBit(bridgeSbDb);
    startTest("wired and");
    sendOp(viaDb | flagBit(loadX), AluAdd, 8'hF0);
    sendOp(viaDb | flagBit(loadY), AluAdd, 8'h3C);
    sendOp(viaDb | flagBit(loadSp), AluAdd, 8'h99);
    // two SB drivers seen on DB
    sendOp(flagBit(setSbToX) | flagBit(setSbToY) | flagBit(bridgeSbDb) |
           flagBit(loadAcc) | flagBit(loadDor), AluAdd, 8'h00);
    // all three buses in one group
    sendOp(flagBit(setSbToSp) | flagBit(setDbToData) | flagBit(setAdhToData) |
           flagBit(bridgeSbDb) | flagBit(bridgeSbAdh) | flagBit(loadAbh) |
           flagBit(loadDor) | flagBit(loadX), AluAdd, 8'hF3);
    sendOp(flagBit(setAdlToSp) | flagBit(setAdlToAlu) | flagBit(loadAbl), AluAdd, 8'h00);
    // nothing drives, precharge shows through
    sendOp(flagBit(loadDor) | flagBit(loadAbh), AluAdd, 8'h12);
    // ADH bridge only, DB stays on its own
    sendOp(flagBit(setSbToY) | flagBit(setAdhToData) | flagBit(bridgeSbAdh) |
           flagBit(setDbToData) | flagBit(loadDor) | flagBit(loadAbh), AluAdd, 8'hE7);
    finishTest();
  endtask

  task automatic testAluOps();
    flagVector viaDb;
    viaDb = flagBit(setDbToData) | flagBit(bridgeSbDb);
    startTest("alu operations");
    sendOp(viaDb | flagBit(loadAluA), AluAdd, 8'hC8);
    sendOp(flagBit(setDbToData) | flagBit(loadAluB), AluAdd, 8'h50);
    // second add picks up the carry of the first
    aluReadback(AluAdd);
    aluReadback(AluAdd);
    aluReadback(AluAnd);
    aluReadback(AluOr);
    aluReadback(AluXor);
    aluReadback(AluShr);
    aluReadback(AluShr);
    // odd operand so the shift carries out
    sendOp(viaDb | flagBit(loadAluA), AluAdd, 8'h35);
    aluReadback(AluShr);
    aluReadback(AluShr);
    aluReadback(AluAdd);
    finishTest();
  endtask

  task automatic testForwarding();
    startTest("forwarding");
    sendOp(flagBit(setDbToData) | flagBit(bridgeSbDb) | flagBit(loadX), AluAdd, 8'h6E);
    sendOp(flagBit(setSbToX) | flagBit(loadY), AluAdd, 8'h00);
    sendOp(flagBit(setSbToY) | flagBit(loadSp) | flagBit(loadAluA), AluAdd, 8'h00);
    sendOp(flagBit(setAdlToSp) | flagBit(loadAbl) | flagBit(setDbToData) |
           flagBit(loadAluB), AluAdd, 8'h21);
    sendOp(flagBit(loadAluHold), AluAdd, 8'h00);
    sendOp(flagBit(setSbToAlu) | flagBit(bridgeSbDb) | flagBit(loadAcc) |
           flagBit(loadDor), AluAdd, 8'h00);
    sendOp(flagBit(setDbToAcc) | flagBit(loadDor) | flagBit(setAdhToData) |
           flagBit(loadAbh), AluAdd, 8'hF0);
    finishTest();
  endtask

  task automatic testRandom();
    flagVector f;
    aluOpCode  op;
    busByte    d;
    int        gap;
    startTest("random sequence");
    for (int i = 0; i < RandomOps; i++) begin
      // two words ANDed keep roughly a quarter of the flags set
      f   = flagVector'(randomBits(FlagCount) & randomBits(FlagCount));
      op  = aluOpCode'(randomBits(3) % 32'd5);
      d   = busByte'(randomBits(8));
      gap = int'(randomBits(2));
      sendOp(f, op, d);
      idleCycles(gap);
    end
    finishTest();
  endtask

  initial begin
    rstN      = 1'b0;
    step      = 1'b0;
    flags     = '0;
    aluOp     = AluAdd;
    dataIn    = 8'h00;
    lfsrState = 32'h7847_5825;
    modelReset();
    repeat (16) @(negedge clk);
    rstN = 1'b1;

    testResetState();
    testDataPaths();
    testWiredAnd();
    testAluOps();
    testForwarding();
    testRandom();

    $display("tests %0d, failed %0d, errors %0d, commits checked %0d",
             testsRun, testsFailed, totalErrors(), checkCount);
    if (totalErrors() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/dataflowPkg.sv
rtl/microOpIf.sv
rtl/registerBank.sv
rtl/busNetwork.sv
rtl/aluUnit.sv
rtl/microOpLatch.sv
rtl/dataflowTop.sv
tests/dataflowTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the dataflow testbench with Verilator
set -e

cd "$(dirname "$0")"

mkdir -p build

verilator --binary --assert \
  --top-module dataflowTb \
  -Mdir build \
  -f list.f

./build/VdataflowTb | tee build/sim.log

if grep -q -F "** PASS **" build/sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
